// File: Makefile
VERILATOR ?= verilator
TOP       ?= axi_ram_tb
RTL_TOP   ?= axi_ram_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

lint-rtl:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/axi_burst_decode.sv
// write and read burst FSMs that split AXI bursts into single memory beats
`default_nettype none
`include "axi_ram_macros.svh"

module axi_burst_decode (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       awvalid,
    output logic                            awready,
    input  wire axi_ram_pkg::axi_id_t       awid,
    input  wire logic [`AXI_RAM_ADDR_W-1:0] awaddr,
    input  wire axi_ram_pkg::axi_len_t      awlen,
    input  wire axi_ram_pkg::axi_size_t     awsize,
    input  wire axi_ram_pkg::axi_burst_e    awburst,
    input  wire logic                       wvalid,
    output logic                            wready,
    input  wire axi_ram_pkg::axi_data_t     wdata,
    input  wire axi_ram_pkg::axi_strb_t     wstrb,
    input  wire logic                       wlast,
    input  wire logic                       b_busy,
    input  wire logic                       arvalid,
    output logic                            arready,
    input  wire axi_ram_pkg::axi_id_t       arid,
    input  wire logic [`AXI_RAM_ADDR_W-1:0] araddr,
    input  wire axi_ram_pkg::axi_len_t      arlen,
    input  wire axi_ram_pkg::axi_size_t     arsize,
    input  wire axi_ram_pkg::axi_burst_e    arburst,
    ram_beat_if.issue                       wr_req,
    ram_beat_if.issue                       rd_req
);

    localparam axi_ram_pkg::axi_size_t MAX_SIZE = 3'($clog2(`AXI_RAM_STRB_W));

    typedef enum logic [1:0] {WR_IDLE, WR_BURST, WR_RESP} wr_state_e;
    typedef enum logic {RD_IDLE, RD_BURST} rd_state_e;

    wr_state_e               wr_state;
    axi_ram_pkg::axi_id_t    wr_id;
    axi_ram_pkg::axi_addr_u  wr_addr;
    axi_ram_pkg::axi_len_t   wr_cnt;
    axi_ram_pkg::axi_size_t  wr_size;
    axi_ram_pkg::axi_burst_e wr_burst;
    logic                    wr_end;

    rd_state_e               rd_state;
    axi_ram_pkg::axi_id_t    rd_id;
    axi_ram_pkg::axi_addr_u  rd_addr;
    axi_ram_pkg::axi_len_t   rd_cnt;
    axi_ram_pkg::axi_size_t  rd_size;
    axi_ram_pkg::axi_burst_e rd_burst;
    logic                    rd_issue;

    // beats wider than the bus are cut down to the bus width
    function automatic axi_ram_pkg::axi_size_t clamp_size(input axi_ram_pkg::axi_size_t size);
        return (size > MAX_SIZE) ? MAX_SIZE : size;
    endfunction

    // WRAP steps like INCR
    function automatic axi_ram_pkg::axi_addr_u next_addr(
        input axi_ram_pkg::axi_addr_u  addr,
        input axi_ram_pkg::axi_size_t  size,
        input axi_ram_pkg::axi_burst_e burst
    );
        axi_ram_pkg::axi_addr_u     result;
        logic [`AXI_RAM_ADDR_W-1:0] step;
        result = addr;
        step = {{(`AXI_RAM_ADDR_W-1){1'b0}}, 1'b1} << size;
        if (burst != axi_ram_pkg::FIXED) begin
            result.raw = addr.raw + step;
        end
        return result;
    endfunction

    // an early wlast also closes the burst
    assign wr_end = (wr_cnt == 8'd0) || wlast;

    assign wr_req.valid = wvalid && wready;
    assign wr_req.addr  = wr_addr;
    assign wr_req.wdata = wdata;
    assign wr_req.wstrb = wstrb;
    assign wr_req.id    = wr_id;
    assign wr_req.last  = wr_end;

    always_ff @(posedge clk) begin
        case (wr_state)
            WR_IDLE: begin
                if (awvalid && awready) begin
                    wr_id       <= awid;
                    wr_addr.raw <= awaddr;
                    wr_cnt      <= awlen;
                    wr_size     <= clamp_size(awsize);
                    wr_burst    <= awburst;
                    awready     <= 1'b0;
                    wready      <= 1'b1;
                    wr_state    <= WR_BURST;
                end else begin
                    awready <= 1'b1;
                end
            end
            WR_BURST: begin
                if (wr_req.valid) begin
                    wr_addr <= next_addr(wr_addr, wr_size, wr_burst);
                    wr_cnt  <= wr_cnt - 8'd1;
                    if (wr_end) begin
                        wready   <= 1'b0;
                        wr_state <= WR_RESP;
                    end
                end
            end
            WR_RESP: begin
                // hold off the next AW until B has been taken
                if (!b_busy) begin
                    awready  <= 1'b1;
                    wr_state <= WR_IDLE;
                end
            end
            default: wr_state <= WR_IDLE;
        endcase
        if (rst) begin
            wr_state <= WR_IDLE;
            awready  <= 1'b0;
            wready   <= 1'b0;
        end
    end

    assign rd_req.valid = (rd_state == RD_BURST);
    assign rd_req.addr  = rd_addr;
    assign rd_req.wdata = '0;
    assign rd_req.wstrb = '0;
    assign rd_req.id    = rd_id;
    assign rd_req.last  = (rd_cnt == 8'd0);
    assign rd_issue     = rd_req.valid && rd_req.ready;

    always_ff @(posedge clk) begin
        case (rd_state)
            RD_IDLE: begin
                if (arvalid && arready) begin
                    rd_id       <= arid;
                    rd_addr.raw <= araddr;
                    rd_cnt      <= arlen;
                    rd_size     <= clamp_size(arsize);
                    rd_burst    <= arburst;
                    arready     <= 1'b0;
                    rd_state    <= RD_BURST;
                end else begin
                    arready <= 1'b1;
                end
            end
            RD_BURST: begin
                if (rd_issue) begin
                    rd_addr <= next_addr(rd_addr, rd_size, rd_burst);
                    rd_cnt  <= rd_cnt - 8'd1;
                    if (rd_cnt == 8'd0) begin
                        arready  <= 1'b1;
                        rd_state <= RD_IDLE;
                    end
                end
            end
        endcase
        if (rst) begin
            rd_state <= RD_IDLE;
            arready  <= 1'b0;
        end
    end

    a_wr_beat_in_burst: assert property (@(posedge clk) disable iff (rst)
        wr_req.valid |-> wr_state == WR_BURST);

    // within one burst the count only falls and never wraps past zero
    a_wr_no_underflow: assert property (@(posedge clk) disable iff (rst)
        (wr_state == WR_BURST && $past(wr_state) == WR_BURST) |-> wr_cnt <= $past(wr_cnt));

    a_rd_no_underflow: assert property (@(posedge clk) disable iff (rst)
        (rd_state == RD_BURST && $past(rd_state) == RD_BURST) |-> rd_cnt <= $past(rd_cnt));

endmodule

`default_nettype wire

// File: design/axi_ram_array.sv
// byte-lane block RAM with a strobed write port and a registered read port
`default_nettype none
`include "axi_ram_macros.svh"

module axi_ram_array (
    input  wire logic clk,
    ram_beat_if.exec  wr_req,
    ram_beat_if.exec  rd_req,
    ram_beat_if.done  wr_done,
    ram_beat_if.done  rd_done
);

    axi_ram_pkg::axi_data_t mem [`AXI_RAM_WORDS];

    logic                   rd_fire;
    logic                   wr_valid_q = 1'b0;
    axi_ram_pkg::axi_id_t   wr_id_q;
    logic                   wr_last_q;
    logic                   rd_valid_q = 1'b0;
    axi_ram_pkg::axi_data_t rd_data_q;
    axi_ram_pkg::axi_id_t   rd_id_q;
    logic                   rd_last_q;

    initial begin
        for (int i = 0; i < `AXI_RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign rd_fire = rd_req.valid && rd_req.ready;

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < `AXI_RAM_STRB_W; lane++) begin
            if (wr_req.valid && wr_req.wstrb[lane]) begin
                mem[wr_req.addr.part.word][8*lane +: 8] <= wr_req.wdata[8*lane +: 8];
            end
        end
        wr_valid_q <= wr_req.valid;
        wr_id_q    <= wr_req.id;
        wr_last_q  <= wr_req.last;
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_data_q <= mem[rd_req.addr.part.word];
            rd_id_q   <= rd_req.id;
            rd_last_q <= rd_req.last;
        end
        rd_valid_q <= rd_fire;
    end

    assign wr_done.valid = wr_valid_q;
    assign wr_done.id    = wr_id_q;
    assign wr_done.last  = wr_last_q;
    // write completion carries no data
    assign wr_done.wdata = '0;

    assign rd_done.valid = rd_valid_q;
    assign rd_done.wdata = rd_data_q;
    assign rd_done.id    = rd_id_q;
    assign rd_done.last  = rd_last_q;

    a_known_wr_addr: assert property (@(posedge clk)
        wr_req.valid |-> !$isunknown(wr_req.addr));

    a_known_rd_addr: assert property (@(posedge clk)
        rd_fire |-> !$isunknown(rd_req.addr));

endmodule

`default_nettype wire

// File: design/axi_ram_macros.svh
// width macros for the AXI RAM address, data, strobe and ID buses
`ifndef AXI_RAM_MACROS_SVH
`define AXI_RAM_MACROS_SVH

// byte address width
`define AXI_RAM_ADDR_W 12
`define AXI_RAM_DATA_W 32
`define AXI_RAM_ID_W 4

// one strobe bit per byte lane
`define AXI_RAM_STRB_W (`AXI_RAM_DATA_W / 8)

// memory depth in bus words
`define AXI_RAM_WORDS (1 << (`AXI_RAM_ADDR_W - $clog2(`AXI_RAM_STRB_W)))

`endif

// File: design/axi_ram_pkg.sv
// burst, data, strobe, ID, length and size types plus the byte address union
`default_nettype none
`include "axi_ram_macros.svh"

package axi_ram_pkg;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    typedef logic [`AXI_RAM_DATA_W-1:0] axi_data_t;
    typedef logic [`AXI_RAM_STRB_W-1:0] axi_strb_t;
    typedef logic [`AXI_RAM_ID_W-1:0]   axi_id_t;
    typedef logic [7:0]                 axi_len_t;
    typedef logic [2:0]                 axi_size_t;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // word index above, byte lane offset below
    typedef struct packed {
        logic [`AXI_RAM_ADDR_W-$clog2(`AXI_RAM_STRB_W)-1:0] word;
        logic [$clog2(`AXI_RAM_STRB_W)-1:0]                 offset;
    } axi_word_addr_t;

    typedef union packed {
        logic [`AXI_RAM_ADDR_W-1:0] raw;
        axi_word_addr_t             part;
    } axi_addr_u;

endpackage

`default_nettype wire

// File: design/axi_ram_top.sv
// AXI4 RAM top level joining burst decode, memory array and response generator
`default_nettype none
`include "axi_ram_macros.svh"

module axi_ram_top (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       awvalid,
    output logic                            awready,
    input  wire axi_ram_pkg::axi_id_t       awid,
    input  wire logic [`AXI_RAM_ADDR_W-1:0] awaddr,
    input  wire axi_ram_pkg::axi_len_t      awlen,
    input  wire axi_ram_pkg::axi_size_t     awsize,
    input  wire axi_ram_pkg::axi_burst_e    awburst,
    input  wire logic                       wvalid,
    output logic                            wready,
    input  wire axi_ram_pkg::axi_data_t     wdata,
    input  wire axi_ram_pkg::axi_strb_t     wstrb,
    input  wire logic                       wlast,
    output logic                            bvalid,
    input  wire logic                       bready,
    output axi_ram_pkg::axi_id_t            bid,
    output logic [1:0]                      bresp,
    input  wire logic                       arvalid,
    output logic                            arready,
    input  wire axi_ram_pkg::axi_id_t       arid,
    input  wire logic [`AXI_RAM_ADDR_W-1:0] araddr,
    input  wire axi_ram_pkg::axi_len_t      arlen,
    input  wire axi_ram_pkg::axi_size_t     arsize,
    input  wire axi_ram_pkg::axi_burst_e    arburst,
    output logic                            rvalid,
    input  wire logic                       rready,
    output axi_ram_pkg::axi_id_t            rid,
    output axi_ram_pkg::axi_data_t          rdata,
    output logic [1:0]                      rresp,
    output logic                            rlast
);

    ram_beat_if wr_req ();
    ram_beat_if rd_req ();
    ram_beat_if wr_done ();
    ram_beat_if rd_done ();

    logic b_busy;
    logic rd_ready;
    logic rd_issue;

    assign rd_req.ready = rd_ready;
    assign rd_issue     = rd_req.valid && rd_req.ready;

    axi_burst_decode u_decode (
        .clk, .rst,
        .awvalid, .awready, .awid, .awaddr, .awlen, .awsize, .awburst,
        .wvalid, .wready, .wdata, .wstrb, .wlast,
        .b_busy,
        .arvalid, .arready, .arid, .araddr, .arlen, .arsize, .arburst,
        .wr_req (wr_req.issue),
        .rd_req (rd_req.issue)
    );

    axi_ram_array u_array (
        .clk,
        .wr_req  (wr_req.exec),
        .rd_req  (rd_req.exec),
        .wr_done (wr_done.done),
        .rd_done (rd_done.done)
    );

    axi_resp_gen u_resp (
        .clk, .rst,
        .wr_done (wr_done.exec),
        .rd_done (rd_done.exec),
        .rd_ready, .rd_issue,
        .bvalid, .bid, .bresp, .bready, .b_busy,
        .rvalid, .rid, .rdata, .rresp, .rlast, .rready
    );

endmodule

`default_nettype wire

// File: design/axi_resp_gen.sv
// B response register and two-entry R queue with in-flight read accounting
`default_nettype none

module axi_resp_gen (
    input  wire logic              clk,
    input  wire logic              rst,
    ram_beat_if.exec               wr_done,
    ram_beat_if.exec               rd_done,
    output logic                   rd_ready,
    input  wire logic              rd_issue,
    output logic                   bvalid,
    output axi_ram_pkg::axi_id_t   bid,
    output logic [1:0]             bresp,
    input  wire logic              bready,
    output logic                   b_busy,
    output logic                   rvalid,
    output axi_ram_pkg::axi_id_t   rid,
    output axi_ram_pkg::axi_data_t rdata,
    output logic [1:0]             rresp,
    output logic                   rlast,
    input  wire logic              rready
);

    axi_ram_pkg::axi_data_t q_data [2];
    axi_ram_pkg::axi_id_t   q_id [2];
    logic                   q_last [2];
    logic                   wr_ptr;
    logic                   rd_ptr;
    logic [1:0]             q_cnt;
    logic [1:0]             in_flight;
    logic                   pop;

    assign bresp  = axi_ram_pkg::AXI_RESP_OKAY;
    // low in the cycle that B is taken so AW can reopen on that edge
    assign b_busy = (wr_done.valid && wr_done.last) || (bvalid && !bready);

    always_ff @(posedge clk) begin
        if (wr_done.valid && wr_done.last && !bvalid) begin
            bvalid <= 1'b1;
            bid    <= wr_done.id;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
        if (rst) begin
            bvalid <= 1'b0;
        end
    end

    assign pop      = rvalid && rready;
    assign rvalid   = (q_cnt != 2'd0);
    assign rdata    = q_data[rd_ptr];
    assign rid      = q_id[rd_ptr];
    assign rlast    = q_last[rd_ptr];
    assign rresp    = axi_ram_pkg::AXI_RESP_OKAY;
    // reserve a slot for every beat still inside the array
    assign rd_ready = ({1'b0, q_cnt} + {1'b0, in_flight}) < 3'd2;

    always_ff @(posedge clk) begin
        if (rd_done.valid) begin
            q_data[wr_ptr] <= rd_done.wdata;
            q_id[wr_ptr]   <= rd_done.id;
            q_last[wr_ptr] <= rd_done.last;
            wr_ptr         <= ~wr_ptr;
        end
        if (pop) begin
            rd_ptr <= ~rd_ptr;
        end
        q_cnt     <= q_cnt + {1'b0, rd_done.valid} - {1'b0, pop};
        in_flight <= in_flight + {1'b0, rd_issue} - {1'b0, rd_done.valid};
        if (rst) begin
            wr_ptr    <= 1'b0;
            rd_ptr    <= 1'b0;
            q_cnt     <= 2'd0;
            in_flight <= 2'd0;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        rd_done.valid |-> (q_cnt != 2'd2 || pop));

    // the head beat holds still while the master stalls
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rid) && $stable(rlast)));

endmodule

`default_nettype wire

// File: design/ram_beat_if.sv
// single memory beat interface with issue, exec and done modports
`default_nettype none

interface ram_beat_if;

    logic                   valid;
    logic                   ready;
    axi_ram_pkg::axi_addr_u addr;
    // also carries read data on the read completion path
    axi_ram_pkg::axi_data_t wdata;
    axi_ram_pkg::axi_strb_t wstrb;
    axi_ram_pkg::axi_id_t   id;
    logic                   last;

    // burst decoder side
    modport issue (
        output valid, addr, wdata, wstrb, id, last,
        input  ready
    );

    modport exec (
        input valid, ready, addr, wdata, wstrb, id, last
    );

    // completion toward the response block, no back-pressure
    modport done (
        output valid, wdata, id, last
    );

endinterface

`default_nettype wire

// File: files.f
+incdir+design
design/axi_ram_pkg.sv
design/ram_beat_if.sv
design/axi_burst_decode.sv
design/axi_ram_array.sv
design/axi_resp_gen.sv
design/axi_ram_top.sv
tests/tb_clock.sv
tests/axi_ram_tb.sv

// File: tests/axi_ram_tb.sv
// AXI RAM testbench with directed burst tests, compare tasks and a byte model
`default_nettype none
`include "axi_ram_macros.svh"

module axi_ram_tb;

    localparam int LIMIT = 200;
    localparam axi_ram_pkg::axi_size_t BUS_SIZE = 3'($clog2(`AXI_RAM_STRB_W));

    logic                       clk, rst;
    logic                       awvalid, awready, wvalid, wready, wlast;
    logic                       bvalid, bready, arvalid, arready, rvalid, rready, rlast;
    axi_ram_pkg::axi_id_t       awid, bid, arid, rid;
    logic [`AXI_RAM_ADDR_W-1:0] awaddr, araddr;
    axi_ram_pkg::axi_len_t      awlen, arlen;
    axi_ram_pkg::axi_size_t     awsize, arsize;
    axi_ram_pkg::axi_burst_e    awburst, arburst;
    axi_ram_pkg::axi_data_t     wdata, rdata;
    axi_ram_pkg::axi_strb_t     wstrb;
    logic [1:0]                 bresp, rresp;

    logic [7:0] model [1 << `AXI_RAM_ADDR_W];
    int         errors;
    int         timeouts;
    int         seed;
    bit         random_rready;
    string      test_name;

    tb_clock u_clock (.clk, .rst);

    axi_ram_top UUT (.*);

    task automatic check_data(input string what, input axi_ram_pkg::axi_data_t exp,
                              input axi_ram_pkg::axi_data_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_id(input string what, input axi_ram_pkg::axi_id_t exp,
                            input axi_ram_pkg::axi_id_t act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_resp(input string what, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("** Error %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("%s: no response, timed out waiting for %s", test_name, what);
    endtask

    function automatic logic [`AXI_RAM_ADDR_W-1:0] step_addr(
        input logic [`AXI_RAM_ADDR_W-1:0] addr,
        input axi_ram_pkg::axi_size_t     size,
        input axi_ram_pkg::axi_burst_e    burst
    );
        axi_ram_pkg::axi_size_t eff;
        eff = (size > BUS_SIZE) ? BUS_SIZE : size;
        if (burst == axi_ram_pkg::FIXED) begin
            return addr;
        end
        return addr + (`AXI_RAM_ADDR_W'(1) << eff);
    endfunction

    // strobe lanes map to the bytes of the addressed word, not to the offset
    task automatic model_write(input logic [`AXI_RAM_ADDR_W-1:0] addr,
                               input axi_ram_pkg::axi_data_t data,
                               input axi_ram_pkg::axi_strb_t strb);
        int base;
        base = int'(addr) & ~(`AXI_RAM_STRB_W - 1);
        for (int lane = 0; lane < `AXI_RAM_STRB_W; lane++) begin
            if (strb[lane]) begin
                model[base + lane] = data[8*lane +: 8];
            end
        end
    endtask

    function automatic axi_ram_pkg::axi_data_t model_word(input logic [`AXI_RAM_ADDR_W-1:0] addr);
        axi_ram_pkg::axi_data_t word;
        int                     base;
        base = int'(addr) & ~(`AXI_RAM_STRB_W - 1);
        for (int lane = 0; lane < `AXI_RAM_STRB_W; lane++) begin
            word[8*lane +: 8] = model[base + lane];
        end
        return word;
    endfunction

    task automatic collect_b(input axi_ram_pkg::axi_id_t id);
        int n;
        bready = 1'b1;
        n = 0;
        while (!bvalid && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) begin
            bready = 1'b0;
            report_timeout("bvalid");
            return;
        end
        check_id("bid", id, bid);
        check_resp("bresp", 2'b00, bresp);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_write(
        input axi_ram_pkg::axi_id_t       id,
        input logic [`AXI_RAM_ADDR_W-1:0] addr,
        input axi_ram_pkg::axi_len_t      len,
        input axi_ram_pkg::axi_size_t     size,
        input axi_ram_pkg::axi_burst_e    burst,
        input axi_ram_pkg::axi_data_t     data[$],
        input axi_ram_pkg::axi_strb_t     strb[$],
        input bit                         take_b
    );
        logic [`AXI_RAM_ADDR_W-1:0] beat_addr;
        int                         n;
        beat_addr = addr;
        awvalid = 1'b1;
        awid = id;
        awaddr = addr;
        awlen = len;
        awsize = size;
        awburst = burst;
        n = 0;
        while (!awready && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!awready) begin
            awvalid = 1'b0;
            report_timeout("awready");
            return;
        end
        @(negedge clk);
        awvalid = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            wvalid = 1'b1;
            wdata = data[i];
            wstrb = strb[i];
            wlast = (i == int'(len));
            n = 0;
            while (!wready && n < LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (!wready) begin
                wvalid = 1'b0;
                report_timeout("wready");
                return;
            end
            model_write(beat_addr, data[i], strb[i]);
            beat_addr = step_addr(beat_addr, size, burst);
            @(negedge clk);
        end
        wvalid = 1'b0;
        wlast = 1'b0;
        check_flag("wready after last beat", 1'b0, wready);
        if (take_b) begin
            collect_b(id);
        end
    endtask

    task automatic axi_read(
        input axi_ram_pkg::axi_id_t       id,
        input logic [`AXI_RAM_ADDR_W-1:0] addr,
        input axi_ram_pkg::axi_len_t      len,
        input axi_ram_pkg::axi_size_t     size,
        input axi_ram_pkg::axi_burst_e    burst
    );
        logic [`AXI_RAM_ADDR_W-1:0] beat_addr;
        int                         beat;
        int                         n;
        int                         rnd;
        beat_addr = addr;
        arvalid = 1'b1;
        arid = id;
        araddr = addr;
        arlen = len;
        arsize = size;
        arburst = burst;
        n = 0;
        while (!arready && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!arready) begin
            arvalid = 1'b0;
            report_timeout("arready");
            return;
        end
        @(negedge clk);
        arvalid = 1'b0;
        beat = 0;
        n = 0;
        while (beat <= int'(len) && n < LIMIT) begin
            if (random_rready) begin
                rnd = $random(seed);
                rready = rnd[0];
            end else begin
                rready = 1'b1;
            end
            if (rvalid && rready) begin
                check_data($sformatf("rdata beat %0d", beat), model_word(beat_addr), rdata);
                check_id("rid", id, rid);
                check_resp("rresp", 2'b00, rresp);
                check_flag($sformatf("rlast beat %0d", beat), beat == int'(len), rlast);
                beat_addr = step_addr(beat_addr, size, burst);
                beat++;
            end
            @(negedge clk);
            n++;
        end
        rready = 1'b0;
        if (beat <= int'(len)) begin
            report_timeout("rvalid");
            return;
        end
        // nothing may be left over once rlast has gone by
        check_flag("rvalid after burst", 1'b0, rvalid);
    endtask

    task automatic reset_and_single_beat();
        axi_ram_pkg::axi_data_t d[$];
        axi_ram_pkg::axi_strb_t s[$];
        test_name = "reset_single";
        check_flag("awready after reset", 1'b1, awready);
        check_flag("arready after reset", 1'b1, arready);
        check_flag("bvalid after reset", 1'b0, bvalid);
        check_flag("rvalid after reset", 1'b0, rvalid);
        d.push_back(32'hCAFE_1234);
        s.push_back(4'hF);
        axi_write(4'd3, 12'h010, 8'd0, 3'd2, axi_ram_pkg::INCR, d, s, 1'b1);
        axi_read(4'd5, 12'h010, 8'd0, 3'd2, axi_ram_pkg::INCR);
    endtask

    task automatic incr_burst_readback();
        axi_ram_pkg::axi_data_t d[$];
        axi_ram_pkg::axi_strb_t s[$];
        test_name = "incr_burst";
        for (int i = 0; i < 8; i++) begin
            d.push_back($random(seed));
            s.push_back(4'hF);
        end
        axi_write(4'd1, 12'h100, 8'd7, 3'd2, axi_ram_pkg::INCR, d, s, 1'b1);
        axi_read(4'd2, 12'h100, 8'd7, 3'd2, axi_ram_pkg::INCR);
    endtask

    task automatic partial_strobe_merge();
        axi_ram_pkg::axi_data_t d[$];
        axi_ram_pkg::axi_strb_t s[$];
        test_name = "partial_strobes";
        for (int i = 0; i < 4; i++) begin
            d.push_back($random(seed));
        end
        s = '{4'b0101, 4'b1010, 4'b0011, 4'b1000};
        axi_write(4'd4, 12'h104, 8'd3, 3'd2, axi_ram_pkg::INCR, d, s, 1'b1);
        axi_read(4'd4, 12'h100, 8'd7, 3'd2, axi_ram_pkg::INCR);
    endtask

    task automatic fixed_and_narrow_bursts();
        axi_ram_pkg::axi_data_t d[$];
        axi_ram_pkg::axi_strb_t s[$];
        test_name = "fixed_narrow";
        for (int i = 0; i < 4; i++) begin
            d.push_back($random(seed));
            s.push_back(4'hF);
        end
        axi_write(4'd8, 12'h200, 8'd3, 3'd2, axi_ram_pkg::FIXED, d, s, 1'b1);
        axi_read(4'd8, 12'h200, 8'd0, 3'd2, axi_ram_pkg::INCR);
        // two halfword beats land in the same word
        d = '{32'h0000_BEEF, 32'hDEAD_0000};
        s = '{4'b0011, 4'b1100};
        axi_write(4'd10, 12'h300, 8'd1, 3'd1, axi_ram_pkg::INCR, d, s, 1'b1);
        axi_read(4'd11, 12'h300, 8'd0, 3'd2, axi_ram_pkg::INCR);
    endtask

    task automatic read_with_random_rready();
        test_name = "random_rready";
        random_rready = 1'b1;
        axi_read(4'd7, 12'h100, 8'd7, 3'd2, axi_ram_pkg::INCR);
        random_rready = 1'b0;
    endtask

    task automatic b_stall_with_read();
        axi_ram_pkg::axi_data_t d[$];
        axi_ram_pkg::axi_strb_t s[$];
        int                     n;
        test_name = "b_stall";
        d.push_back($random(seed));
        d.push_back($random(seed));
        s = '{4'hF, 4'hF};
        axi_write(4'd9, 12'h040, 8'd1, 3'd2, axi_ram_pkg::INCR, d, s, 1'b0);
        n = 0;
        while (!bvalid && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) begin
            report_timeout("bvalid");
            return;
        end
        repeat (3) begin
            @(negedge clk);
            check_flag("bvalid held", 1'b1, bvalid);
            check_flag("awready with B pending", 1'b0, awready);
        end
        axi_read(4'd6, 12'h100, 8'd3, 3'd2, axi_ram_pkg::INCR);
        check_flag("bvalid after read", 1'b1, bvalid);
        check_flag("awready after read", 1'b0, awready);
        collect_b(4'd9);
        check_flag("awready after B", 1'b1, awready);
        axi_read(4'd12, 12'h040, 8'd1, 3'd2, axi_ram_pkg::INCR);
    endtask

    initial begin
        int n;
        seed = 77735;
        errors = 0;
        timeouts = 0;
        random_rready = 1'b0;
        test_name = "reset";
        awvalid = 1'b0;
        awid = '0;
        awaddr = '0;
        awlen = '0;
        awsize = '0;
        awburst = axi_ram_pkg::FIXED;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        bready = 1'b0;
        arvalid = 1'b0;
        arid = '0;
        araddr = '0;
        arlen = '0;
        arsize = '0;
        arburst = axi_ram_pkg::FIXED;
        rready = 1'b0;
        for (int i = 0; i < (1 << `AXI_RAM_ADDR_W); i++) begin
            model[i] = 8'h00;
        end
        n = 0;
        @(posedge clk);
        while (rst && n < LIMIT) begin
            @(posedge clk);
            n++;
        end
        @(negedge clk);
        if (rst) begin
            report_timeout("reset release");
        end else begin
            reset_and_single_beat();
            incr_burst_readback();
            partial_strobe_merge();
            fixed_and_narrow_bursts();
            read_with_random_rready();
            b_stall_with_read();
        end
        $display("summary: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// testbench clock with a 20 unit period and a two cycle reset
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        // release on the falling edge like every other input
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire
